// ==== logic/serial_bus_pkg.sv ====
//////////////////////////////
// Sizes, ids and packed types shared by every block of the bus
// Node ids are fixed by position, so no id may equal BROADCAST_ID
//////////////////////////////

package serial_bus_pkg;

  //////////////////////////////
  // Bus sizes
  //////////////////////////////

  // Nodes sharing the serial line
  localparam int NODES = 4;

  // Round-robin pointer width
  localparam int PTR_W = $clog2(NODES);

  // Node id and destination field width
  localparam int ID_W = 8;

  // Whole packet, destination on top
  localparam int PKT_W = 16;
  localparam int PAYLOAD_W = PKT_W - ID_W;

  // Must hold PKT_W itself
  localparam int CNT_W = $clog2(PKT_W) + 1;

  //////////////////////////////
  // Packed types
  //////////////////////////////

  typedef logic [ID_W-1:0] node_id_t;

  // Every node accepts this destination
  localparam node_id_t BROADCAST_ID = '1;

  typedef struct packed {
    node_id_t dest;
    logic [PAYLOAD_W-1:0] payload;
  } pkt_t;

  // One bit on the wire, busy marks a valid bit this cycle
  typedef struct packed {
    logic busy;
    logic data;
  } bus_line_t;

endpackage

// ==== logic/bus_arbiter.sv ====
//////////////////////////////
// Round-robin arbiter, grant is combinational from pointer and requests
// A requester must hold bus_req until its last bit is on the line
//////////////////////////////

`timescale 1ns/1ps

module bus_arbiter (
  input  logic                                         clk,
  input  logic                                         rst,
  input  logic [serial_bus_pkg::NODES-1:0]             bus_req,
  input  serial_bus_pkg::bus_line_t [serial_bus_pkg::NODES-1:0] tx_line,
  output logic [serial_bus_pkg::NODES-1:0]             grant,
  output serial_bus_pkg::bus_line_t                    line
);

  logic [serial_bus_pkg::PTR_W-1:0] ptr;
  logic                             any_grant;
  logic                             any_req;

  //////////////////////////////
  // Grant decode
  //////////////////////////////

  // Only the node under the pointer can win
  always_comb begin
    for (int i = 0; i < serial_bus_pkg::NODES; i++) begin
      grant[i] = bus_req[i] && (int'(ptr) == i);
    end
  end

  assign any_grant = |grant;
  assign any_req   = |bus_req;

  //////////////////////////////
  // Pointer
  //////////////////////////////

  // Steps past idle nodes one per cycle, frozen while the bus is owned
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ptr <= '0;
    end else if (!any_grant && any_req) begin
      if (int'(ptr) == serial_bus_pkg::NODES - 1) begin
        ptr <= '0;
      end else begin
        ptr <= ptr + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Shared line mux
  //////////////////////////////

  // Grant is one-hot or zero, so an OR of masked lines is a mux
  always_comb begin
    line = '0;
    for (int i = 0; i < serial_bus_pkg::NODES; i++) begin
      if (grant[i]) begin
        line = line | tx_line[i];
      end
    end
  end

endmodule

// ==== logic/node_tx.sv ====
//////////////////////////////
// Transmit side of a node, sends one packet MSB first per grant
// pop is combinational on pndng while idle
//////////////////////////////

`timescale 1ns/1ps

module node_tx (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      pndng,
  input  serial_bus_pkg::pkt_t      d_pop,
  input  logic                      grant,
  output logic                      pop,
  output logic                      bus_req,
  output serial_bus_pkg::bus_line_t tx_line
);

  typedef enum logic [1:0] {
    st_idle,
    st_req,
    st_send
  } tx_state_t;

  tx_state_t                          state;
  logic [serial_bus_pkg::PKT_W-1:0]   shreg;
  logic [serial_bus_pkg::CNT_W-1:0]   cnt;
  logic                               sending;
  logic                               last_bit;

  //////////////////////////////
  // Handshake outputs
  //////////////////////////////

  // Take the FIFO head as soon as we are free
  assign pop = (state == st_idle) && pndng;

  // Held through the last bit, drops with the return to idle
  assign bus_req = (state != st_idle);

  // A bit leaves on every granted cycle, the first one included
  assign sending  = bus_req && grant;
  assign last_bit = (int'(cnt) == serial_bus_pkg::PKT_W - 1);

  assign tx_line.busy = sending;
  assign tx_line.data = sending && shreg[serial_bus_pkg::PKT_W-1];

  //////////////////////////////
  // Control FSM and bit counter
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      case (state)
        st_idle: begin
          cnt <= '0;
          if (pndng) begin
            state <= st_req;
          end
        end
        st_req: begin
          // Wait here for our turn
          if (grant) begin
            cnt   <= cnt + 1'b1;
            state <= st_send;
          end
        end
        st_send: begin
          if (last_bit) begin
            cnt   <= '0;
            state <= st_idle;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Packet register, loaded on pop and shifted toward the MSB
  always_ff @(posedge clk) begin
    if (pop) begin
      shreg <= d_pop;
    end else if (sending) begin
      shreg <= {shreg[serial_bus_pkg::PKT_W-2:0], 1'b0};
    end
  end

endmodule

// ==== logic/node_rx.sv ====
//////////////////////////////
// Receive side of a node, collects PKT_W enabled bits MSB first
// Pushes one cycle after the last bit when the destination matches
//////////////////////////////

`timescale 1ns/1ps

module node_rx #(
  parameter serial_bus_pkg::node_id_t node_id = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 rx_en,
  input  logic                 rx_bit,
  output logic                 push,
  output serial_bus_pkg::pkt_t d_push
);

  logic [serial_bus_pkg::PKT_W-1:0] shreg;
  logic [serial_bus_pkg::CNT_W-1:0] cnt;
  serial_bus_pkg::pkt_t             next_pkt;
  logic                             last_bit;
  logic                             addr_hit;

  //////////////////////////////
  // Address filter
  //////////////////////////////

  // Packet as it stands once the current bit is in
  assign next_pkt = {shreg[serial_bus_pkg::PKT_W-2:0], rx_bit};

  assign last_bit = rx_en && (int'(cnt) == serial_bus_pkg::PKT_W - 1);

  assign addr_hit = (next_pkt.dest == node_id) ||
                    (next_pkt.dest == serial_bus_pkg::BROADCAST_ID);

  //////////////////////////////
  // Bit counter and push flag
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt  <= '0;
      push <= 1'b0;
    end else begin
      push <= last_bit && addr_hit;
      if (last_bit) begin
        // Ready for the next packet right away
        cnt <= '0;
      end else if (rx_en) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Data path
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rx_en) begin
      shreg <= next_pkt;
    end
  end

  // Holds the packet for the push cycle, don't care otherwise
  always_ff @(posedge clk) begin
    if (last_bit) begin
      d_push <= next_pkt;
    end
  end

endmodule

// ==== logic/bus_node.sv ====
//////////////////////////////
// One bus node, node_id is its position on the bus
//////////////////////////////

`timescale 1ns/1ps

module bus_node #(
  parameter serial_bus_pkg::node_id_t node_id = '0
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      pndng,
  input  serial_bus_pkg::pkt_t      d_pop,
  input  logic                      grant,
  input  serial_bus_pkg::bus_line_t line,
  output logic                      pop,
  output logic                      bus_req,
  output serial_bus_pkg::bus_line_t tx_line,
  output logic                      push,
  output serial_bus_pkg::pkt_t      d_push
);

  logic rx_en;

  // Listen to every bit on the line except our own
  assign rx_en = line.busy && !grant;

  node_tx u_tx (
    .clk     (clk),
    .rst     (rst),
    .pndng   (pndng),
    .d_pop   (d_pop),
    .grant   (grant),
    .pop     (pop),
    .bus_req (bus_req),
    .tx_line (tx_line)
  );

  node_rx #(
    .node_id (node_id)
  ) u_rx (
    .clk    (clk),
    .rst    (rst),
    .rx_en  (rx_en),
    .rx_bit (line.data),
    .push   (push),
    .d_push (d_push)
  );

endmodule

// ==== logic/serial_bus.sv ====
//////////////////////////////
// Four-node serial packet bus with a central round-robin arbiter
// Receive FIFOs must always accept push, there is no back-pressure
//////////////////////////////

`timescale 1ns/1ps

module serial_bus (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic [serial_bus_pkg::NODES-1:0]                  pndng,
  input  serial_bus_pkg::pkt_t [serial_bus_pkg::NODES-1:0]  d_pop,
  output logic [serial_bus_pkg::NODES-1:0]                  pop,
  output logic [serial_bus_pkg::NODES-1:0]                  push,
  output serial_bus_pkg::pkt_t [serial_bus_pkg::NODES-1:0]  d_push
);

  logic [serial_bus_pkg::NODES-1:0]                      bus_req;
  logic [serial_bus_pkg::NODES-1:0]                      grant;
  serial_bus_pkg::bus_line_t [serial_bus_pkg::NODES-1:0] tx_line;
  serial_bus_pkg::bus_line_t                             line;

  //////////////////////////////
  // Node array
  //////////////////////////////

  for (genvar i = 0; i < serial_bus_pkg::NODES; i++) begin : g_node
    bus_node #(
      .node_id (serial_bus_pkg::node_id_t'(i))
    ) u_node (
      .clk     (clk),
      .rst     (rst),
      .pndng   (pndng[i]),
      .d_pop   (d_pop[i]),
      .grant   (grant[i]),
      .line    (line),
      .pop     (pop[i]),
      .bus_req (bus_req[i]),
      .tx_line (tx_line[i]),
      .push    (push[i]),
      .d_push  (d_push[i])
    );
  end

  //////////////////////////////
  // Arbiter and line mux
  //////////////////////////////

  bus_arbiter u_arbiter (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .tx_line (tx_line),
    .grant   (grant),
    .line    (line)
  );

endmodule

// ==== tb/serial_bus_checker.sv ====
//////////////////////////////
// Bus protocol assertions, bound into serial_bus
//////////////////////////////

`timescale 1ns/1ps

module serial_bus_checker (
  input logic                             clk,
  input logic                             rst,
  input logic [serial_bus_pkg::NODES-1:0] grant,
  input logic [serial_bus_pkg::NODES-1:0] bus_req,
  input serial_bus_pkg::bus_line_t        line,
  input logic [serial_bus_pkg::NODES-1:0] pop,
  input logic [serial_bus_pkg::NODES-1:0] push
);

  // Assertion failures so far
  int fail_cnt = 0;

  // At most one owner of the line
  a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else begin
      fail_cnt++;
      $error("grant %b is not one-hot or zero", grant);
    end

  a_grant_req: assert property (@(posedge clk) disable iff (rst) (grant & ~bus_req) == '0)
    else begin
      fail_cnt++;
      $error("grant %b given to a node without a request %b", grant, bus_req);
    end

  a_line_owned: assert property (@(posedge clk) disable iff (rst) line.busy |-> (grant != '0))
    else begin
      fail_cnt++;
      $error("line busy with no grant");
    end

  // Handshake strobes last a single cycle
  a_pop_pulse: assert property (@(posedge clk) disable iff (rst) (pop & $past(pop)) == '0)
    else begin
      fail_cnt++;
      $error("pop %b held for more than one cycle", pop);
    end

  a_push_pulse: assert property (@(posedge clk) disable iff (rst) (push & $past(push)) == '0)
    else begin
      fail_cnt++;
      $error("push %b held for more than one cycle", push);
    end

endmodule

bind serial_bus serial_bus_checker chk (
  .clk     (clk),
  .rst     (rst),
  .grant   (grant),
  .bus_req (bus_req),
  .line    (line),
  .pop     (pop),
  .push    (push)
);

// ==== tb/serial_bus_tb.sv ====
//////////////////////////////
// Testbench for serial_bus, queue models stand in for every local FIFO
// Payload top bits carry the sender id so deliveries can be traced
//////////////////////////////

`timescale 1ns/1ps

module serial_bus_tb;

  logic                                             clk;
  logic                                             rst;
  logic [serial_bus_pkg::NODES-1:0]                 pndng;
  serial_bus_pkg::pkt_t [serial_bus_pkg::NODES-1:0] d_pop;
  logic [serial_bus_pkg::NODES-1:0]                 pop;
  logic [serial_bus_pkg::NODES-1:0]                 push;
  serial_bus_pkg::pkt_t [serial_bus_pkg::NODES-1:0] d_push;

  // Transmit FIFO contents per node
  serial_bus_pkg::pkt_t tx_q [serial_bus_pkg::NODES][$];
  // Expected deliveries, indexed by sender * NODES + receiver
  serial_bus_pkg::pkt_t exp_q [serial_bus_pkg::NODES*serial_bus_pkg::NODES][$];

  int    seed = 32'h6f78;
  int    err_cnt = 0;
  int    n_tests = 0;
  int    n_failed = 0;
  int    test_err_base = 0;
  string test_name = "reset";

  serial_bus dut (
    .clk    (clk),
    .rst    (rst),
    .pndng  (pndng),
    .d_pop  (d_pop),
    .pop    (pop),
    .push   (push),
    .d_push (d_push)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Every test fits in a few full rounds of NODES packets
  initial begin
    int limit;
    limit = 5 * serial_bus_pkg::NODES * (serial_bus_pkg::PKT_W + serial_bus_pkg::NODES + 4) * 4;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, test %s never finished", limit, test_name);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////
  // FIFO models and scoreboard
  //////////////////////////////

  // Present each FIFO head just after the clock edge
  always @(posedge clk) begin
    #1;
    for (int n = 0; n < serial_bus_pkg::NODES; n++) begin
      pndng[n] = (tx_q[n].size() != 0);
      d_pop[n] = (tx_q[n].size() != 0) ? tx_q[n][0] : '0;
    end
  end

  // Mid-cycle sampling of pop and push
  always @(negedge clk) begin
    int src;
    int idx;
    if (!rst) begin
      for (int n = 0; n < serial_bus_pkg::NODES; n++) begin
        assert (!pop[n] || pndng[n])
          else begin
            err_cnt++;
            $error("node %0d popped an empty FIFO in %s", n, test_name);
          end
        if (pop[n] && tx_q[n].size() != 0) begin
          void'(tx_q[n].pop_front());
        end
        if (push[n]) begin
          src = int'(d_push[n].payload[serial_bus_pkg::PAYLOAD_W-1 -: serial_bus_pkg::PTR_W]);
          idx = src * serial_bus_pkg::NODES + n;
          assert (exp_q[idx].size() != 0)
            else begin
              err_cnt++;
              $error("node %0d pushed %h with no delivery due in %s", n, d_push[n], test_name);
            end
          if (exp_q[idx].size() != 0) begin
            assert (d_push[n] == exp_q[idx][0])
              else begin
                err_cnt++;
                $error("mismatch %s node %0d expected %h actual %h",
                       test_name, n, exp_q[idx][0], d_push[n]);
              end
            void'(exp_q[idx].pop_front());
          end
        end
      end
    end
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic int total_errors();
    return err_cnt + dut.chk.fail_cnt;
  endfunction

  // Queue one packet at src and note who must receive it
  task automatic send_packet(input int src, input serial_bus_pkg::node_id_t dest);
    serial_bus_pkg::pkt_t pkt;
    int                   rnd;
    rnd = $random(seed);
    pkt.dest = dest;
    pkt.payload = {src[serial_bus_pkg::PTR_W-1:0],
                   rnd[serial_bus_pkg::PAYLOAD_W-serial_bus_pkg::PTR_W-1:0]};
    tx_q[src].push_back(pkt);
    for (int n = 0; n < serial_bus_pkg::NODES; n++) begin
      if (n != src && (dest == serial_bus_pkg::BROADCAST_ID || int'(dest) == n)) begin
        exp_q[src * serial_bus_pkg::NODES + n].push_back(pkt);
      end
    end
  endtask

  // Return once every FIFO is empty and nobody holds the bus
  task automatic drain_bus();
    bit busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = (pndng != '0) || (dut.bus_req != '0);
      for (int n = 0; n < serial_bus_pkg::NODES; n++) begin
        if (tx_q[n].size() != 0) begin
          busy = 1'b1;
        end
      end
    end
    // Last push lands one cycle after the final bit
    repeat (2) @(negedge clk);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_err_base = total_errors();
  endtask

  task automatic end_test();
    int missing;
    int errs;
    missing = 0;
    for (int i = 0; i < serial_bus_pkg::NODES * serial_bus_pkg::NODES; i++) begin
      missing += exp_q[i].size();
      exp_q[i].delete();
    end
    assert (missing == 0)
      else begin
        err_cnt++;
        $error("%0d expected deliveries never arrived in %s", missing, test_name);
      end
    errs = total_errors() - test_err_base;
    n_tests++;
    if (errs == 0) begin
      $display("test %s done, no errors", test_name);
    end else begin
      n_failed++;
      $display("test %s done, %0d errors", test_name, errs);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    int rnd;
    int off;
    rst = 1'b1;
    pndng = '0;
    d_pop = '0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;

    // Nothing queued, so no pop and no push may appear
    begin_test("reset_idle");
    repeat (serial_bus_pkg::NODES * serial_bus_pkg::PKT_W) @(negedge clk);
    end_test();

    begin_test("unicast");
    send_packet(0, serial_bus_pkg::node_id_t'(2));
    drain_bus();
    end_test();

    begin_test("broadcast");
    send_packet(1, serial_bus_pkg::BROADCAST_ID);
    drain_bus();
    end_test();

    begin_test("discard");
    send_packet(0, serial_bus_pkg::node_id_t'(7));
    drain_bus();
    end_test();

    // Three packets per node, never addressed to the sender
    begin_test("contention");
    for (int k = 0; k < 3; k++) begin
      for (int s = 0; s < serial_bus_pkg::NODES; s++) begin
        rnd = $random(seed);
        off = 1 + ((rnd & 32'h7fff_ffff) % (serial_bus_pkg::NODES - 1));
        send_packet(s, serial_bus_pkg::node_id_t'((s + off) % serial_bus_pkg::NODES));
      end
    end
    drain_bus();
    end_test();

    $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errors());
    if (total_errors() == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== serial_bus.f ====
logic/serial_bus_pkg.sv
logic/bus_arbiter.sv
logic/node_tx.sv
logic/node_rx.sv
logic/bus_node.sv
logic/serial_bus.sv
tb/serial_bus_checker.sv
tb/serial_bus_tb.sv

// ==== Makefile ====
# Verilator build and run for the serial bus testbench

VERILATOR ?= verilator
TOP       ?= serial_bus_tb
FILELIST  ?= serial_bus.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf $(BUILD_DIR)
